//--- verilog/oramPkg.sv
/* ORAM definitions
   Tree geometry, block and leaf types, and the client command encoding */
package oramPkg;

	// --------------------
	// Tree geometry
	// --------------------

	// Levels from root to leaf
	localparam int ORAML = 3;
	// Slots in every bucket
	localparam int ORAMZ = 2;
	// Program blocks addressable by the client
	localparam int NumBlocks = 8;
	// One entry per block so the stash never fills
	localparam int StashSize = 8;
	// One burst per slot on a path
	localparam int PathBursts = ORAML * ORAMZ;

	// Nonzero start for the remapping LFSR
	localparam logic [15:0] LfsrSeed = 16'hace1;

	// --------------------
	// Block fields
	// --------------------

	// Program block address
	typedef logic [2:0] addrT;
	// Leaf number whose top bit picks the root child
	typedef logic [1:0] leafT;
	// Block payload
	typedef logic [31:0] dataT;

	// Client command
	typedef enum logic {
		CmdRead,
		CmdWrite
	} cmdT;

endpackage

//--- verilog/dramPkg.sv
/* DRAM definitions
   Command encoding, slot address and the packing of one slot per burst */
package dramPkg;

	// Bucket index times two plus slot, buckets in heap order
	typedef logic [3:0] dramAddrT;

	typedef enum logic {
		DramRead,
		DramWrite
	} dramCmdT;

	// Slot layout from the top bit down
	// valid, address, leaf, data
	localparam int SlotWidth = 38;
	localparam int SlotValidBit = 37;
	localparam int SlotAddrLsb = 34;
	localparam int SlotLeafLsb = 32;
	localparam int SlotDataLsb = 0;

	typedef logic [SlotWidth-1:0] burstT;

endpackage

//--- verilog/oramBackendIf.sv
`timescale 1ns/1ps
/* Front end to back end link
   Access command with both leaves, plus the store and load data streams */
interface oramBackendIf;

	// Command stream held by the front end for the whole access
	oramPkg::cmdT cmd;
	oramPkg::addrT addr;
	oramPkg::leafT oldLeaf;
	oramPkg::leafT newLeaf;
	logic cmdValid;
	logic cmdReady;

	// One beat per write access
	oramPkg::dataT storeData;
	logic storeValid;
	logic storeReady;

	// One beat per read access
	oramPkg::dataT loadData;
	logic loadValid;
	logic loadReady;

	modport front (
		output cmd, addr, oldLeaf, newLeaf, cmdValid, storeData, storeValid, loadReady,
		input cmdReady, storeReady, loadData, loadValid
	);

	modport back (
		input cmd, addr, oldLeaf, newLeaf, cmdValid, storeData, storeValid, loadReady,
		output cmdReady, storeReady, loadData, loadValid
	);

endinterface

//--- verilog/oramFrontend.sv
`timescale 1ns/1ps
/* ORAM front end
   Position map lookup and remap, fresh leaves from an LFSR, data stream bridging */
module oramFrontend (
	input  logic          Clock,
	input  logic          arstN,
	input  oramPkg::cmdT  Cmd,
	input  oramPkg::addrT PAddr,
	input  logic          CmdValid,
	output logic          CmdReady,
	input  oramPkg::dataT DataIn,
	input  logic          DataInValid,
	output logic          DataInReady,
	output oramPkg::dataT DataOut,
	output logic          DataOutValid,
	input  logic          DataOutReady,
	oramBackendIf.front   be
);

	oramPkg::leafT posMap [oramPkg::NumBlocks];
	logic [15:0] lfsr;
	logic lfsrFb;
	logic idle;
	logic pending;
	oramPkg::cmdT cmdQ;
	oramPkg::addrT addrQ;
	oramPkg::leafT oldLeafQ;
	oramPkg::leafT newLeafQ;
	logic accept;

	assign accept = CmdValid && idle;
	assign CmdReady = idle;

	// Taps 16 14 13 11
	assign lfsrFb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

	// --------------------
	// Access control
	// --------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			idle <= 1'b0;
			pending <= 1'b0;
			lfsr <= oramPkg::LfsrSeed;
			// All blocks start on leaf 0
			for (int i = 0; i < oramPkg::NumBlocks; i++) begin
				posMap[i] <= '0;
			end
		end else if (idle) begin
			if (CmdValid) begin
				idle <= 1'b0;
				pending <= 1'b1;
				lfsr <= {lfsr[14:0], lfsrFb};
				// Remap in the same cycle as the lookup
				posMap[PAddr] <= lfsr[1:0];
			end
		end else if (!pending) begin
			// First cycle out of reset
			idle <= 1'b1;
		end else if (be.cmdReady) begin
			// Back end finished the access
			pending <= 1'b0;
			idle <= 1'b1;
		end
	end

	// Command fields held until the back end accepts
	always_ff @(posedge Clock) begin
		if (accept) begin
			cmdQ <= Cmd;
			addrQ <= PAddr;
			oldLeafQ <= posMap[PAddr];
			newLeafQ <= lfsr[1:0];
		end
	end

	assign be.cmd = cmdQ;
	assign be.addr = addrQ;
	assign be.oldLeaf = oldLeafQ;
	assign be.newLeaf = newLeafQ;
	assign be.cmdValid = pending;

	// --------------------
	// Data streams
	// --------------------

	assign be.storeData = DataIn;
	assign be.storeValid = DataInValid;
	assign DataInReady = be.storeReady;

	assign DataOut = be.loadData;
	assign DataOutValid = be.loadValid;
	assign be.loadReady = DataOutReady;

endmodule

//--- verilog/pathBuffer.sv
`timescale 1ns/1ps
/* Path buffer
   Circular FIFO one path deep between DRAM read returns and the stash */
module pathBuffer (
	input  logic           Clock,
	input  logic           arstN,
	input  dramPkg::burstT inData,
	input  logic           inValid,
	output dramPkg::burstT outData,
	output logic           outValid,
	input  logic           outReady
);

	dramPkg::burstT mem [oramPkg::PathBursts];
	logic [2:0] wrPtr;
	logic [2:0] rdPtr;
	logic [2:0] count;
	logic push;
	logic pop;

	// DRAM has no ready and a full path never overruns
	assign push = inValid && (count != 3'(oramPkg::PathBursts));
	assign pop = outValid && outReady;

	assign outValid = (count != 3'd0);
	// Head entry written one cycle earlier at the soonest
	assign outData = mem[rdPtr];

	always_ff @(posedge Clock) begin
		if (push) begin
			mem[wrPtr] <= inData;
		end
	end

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wrPtr <= (wrPtr == 3'(oramPkg::PathBursts - 1)) ? 3'd0 : wrPtr + 3'd1;
			end
			if (pop) begin
				rdPtr <= (rdPtr == 3'(oramPkg::PathBursts - 1)) ? 3'd0 : rdPtr + 3'd1;
			end
			// Occupancy
			case ({push, pop})
				2'b10: count <= count + 3'd1;
				2'b01: count <= count - 3'd1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- verilog/oramStash.sv
`timescale 1ns/1ps
/* Stash
   Block storage with address lookup, path insert, leaf update and eviction pick */
module oramStash (
	input  logic           Clock,
	input  logic           arstN,
	input  dramPkg::burstT insertSlot,
	input  logic           insertValid,
	input  oramPkg::addrT  lookAddr,
	input  oramPkg::leafT  setLeaf,
	input  logic           setLeafEn,
	input  oramPkg::dataT  writeData,
	input  logic           writeEn,
	input  logic [1:0]     evictLevel,
	input  oramPkg::leafT  evictLeaf,
	input  logic           evictTake,
	output oramPkg::dataT  readData,
	output logic           found,
	output dramPkg::burstT evictSlot
);

	logic entValid [oramPkg::StashSize];
	oramPkg::addrT entAddr [oramPkg::StashSize];
	oramPkg::leafT entLeaf [oramPkg::StashSize];
	oramPkg::dataT entData [oramPkg::StashSize];

	logic [2:0] hitIdx;
	logic [2:0] freeIdx;
	logic [2:0] evictIdx;
	logic hasFree;
	logic insDup;
	logic evictHit;
	logic doInsert;
	oramPkg::leafT leafMask;

	// Incoming slot fields
	logic insValid;
	oramPkg::addrT insAddr;
	oramPkg::leafT insLeaf;
	oramPkg::dataT insData;

	assign insValid = insertSlot[dramPkg::SlotValidBit];
	assign insAddr = insertSlot[dramPkg::SlotAddrLsb +: $bits(oramPkg::addrT)];
	assign insLeaf = insertSlot[dramPkg::SlotLeafLsb +: $bits(oramPkg::leafT)];
	assign insData = insertSlot[dramPkg::SlotDataLsb +: $bits(oramPkg::dataT)];

	// Level 0 matches anything, level 2 needs the full leaf
	assign leafMask = ~(oramPkg::leafT'(2'b11) >> evictLevel);

	// --------------------
	// Searches
	// --------------------

	// Scan downward so the lowest index wins
	always_comb begin
		found = 1'b0;
		hitIdx = '0;
		insDup = 1'b0;
		hasFree = 1'b0;
		freeIdx = '0;
		evictHit = 1'b0;
		evictIdx = '0;
		for (int i = oramPkg::StashSize - 1; i >= 0; i--) begin
			if (entValid[i] && entAddr[i] == lookAddr) begin
				found = 1'b1;
				hitIdx = 3'(i);
			end
			if (entValid[i] && entAddr[i] == insAddr) begin
				insDup = 1'b1;
			end
			if (!entValid[i]) begin
				hasFree = 1'b1;
				freeIdx = 3'(i);
			end
			if (entValid[i] && ((entLeaf[i] ^ evictLeaf) & leafMask) == '0) begin
				evictHit = 1'b1;
				evictIdx = 3'(i);
			end
		end
	end

	assign readData = found ? entData[hitIdx] : '0;
	// Invalid slot when no block fits this bucket
	assign evictSlot = evictHit ?
		{1'b1, entAddr[evictIdx], entLeaf[evictIdx], entData[evictIdx]} : '0;

	// Already held blocks are not copied twice
	assign doInsert = insertValid && insValid && !insDup && hasFree;

	// --------------------
	// Updates
	// --------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < oramPkg::StashSize; i++) begin
				entValid[i] <= 1'b0;
			end
		end else begin
			if (doInsert) begin
				entValid[freeIdx] <= 1'b1;
			end
			// Missing block gets created
			if (setLeafEn && !found && hasFree) begin
				entValid[freeIdx] <= 1'b1;
			end
			if (evictTake && evictHit) begin
				entValid[evictIdx] <= 1'b0;
			end
		end
	end

	always_ff @(posedge Clock) begin
		if (doInsert) begin
			entAddr[freeIdx] <= insAddr;
			entLeaf[freeIdx] <= insLeaf;
			entData[freeIdx] <= insData;
		end
		if (setLeafEn) begin
			if (found) begin
				entLeaf[hitIdx] <= setLeaf;
			end else if (hasFree) begin
				entAddr[freeIdx] <= lookAddr;
				entLeaf[freeIdx] <= setLeaf;
				entData[freeIdx] <= '0;
			end
		end
		if (writeEn && found) begin
			entData[hitIdx] <= writeData;
		end
	end

endmodule

//--- verilog/pathOramBackend.sv
`timescale 1ns/1ps
/* Path ORAM back end
   Reads the old path into the stash, serves the block, writes the path back */
module pathOramBackend (
	input  logic              Clock,
	input  logic              arstN,
	input  dramPkg::burstT    rdData,
	input  logic              rdValid,
	output logic              rdReady,
	output dramPkg::dramAddrT DRAMAddress,
	output dramPkg::dramCmdT  DRAMCommand,
	output logic              DRAMCommandValid,
	input  logic              DRAMCommandReady,
	output dramPkg::burstT    DRAMWriteData,
	output logic              DRAMWriteDataValid,
	input  logic              DRAMWriteDataReady,
	oramBackendIf.back        be
);

	typedef enum logic [2:0] {
		Idle,
		ReadCmd,
		Absorb,
		Serve,
		WriteCmd,
		WriteData,
		Done
	} stateT;

	stateT state;
	logic [2:0] cmdCnt;
	logic [2:0] absCnt;
	logic [1:0] rdLevel;
	logic [1:0] wrLevel;
	logic found;
	logic loadFire;
	logic storeFire;
	logic lastBurst;

	// Slot address along the path of leaf at one level
	function automatic dramPkg::dramAddrT slotAddr(
		input oramPkg::leafT leaf,
		input logic [1:0] level,
		input logic slot
	);
		logic [3:0] bucket;
		// First bucket of the level plus the leaf prefix
		bucket = 4'((1 << level) - 1) + 4'(leaf >> (oramPkg::ORAML - 1 - level));
		return dramPkg::dramAddrT'(bucket * oramPkg::ORAMZ + slot);
	endfunction

	// Root first on reads, leaf first on writes
	assign rdLevel = cmdCnt[2:1];
	assign wrLevel = 2'(oramPkg::ORAML - 1) - cmdCnt[2:1];
	assign lastBurst = (cmdCnt == 3'(oramPkg::PathBursts - 1));

	// --------------------
	// DRAM side
	// --------------------

	assign DRAMCommandValid = (state == ReadCmd) || (state == WriteCmd);
	assign DRAMCommand = (state == WriteCmd) ? dramPkg::DramWrite : dramPkg::DramRead;
	assign DRAMAddress = slotAddr(be.oldLeaf, (state == WriteCmd) ? wrLevel : rdLevel,
		cmdCnt[0]);
	assign DRAMWriteDataValid = (state == WriteData);
	assign rdReady = (state == Absorb);

	// --------------------
	// Front end side
	// --------------------

	// Load and store wait until the block exists
	assign be.loadValid = (state == Serve) && found && (be.cmd == oramPkg::CmdRead);
	assign be.storeReady = (state == Serve) && found && (be.cmd == oramPkg::CmdWrite);
	assign be.cmdReady = (state == Done);
	assign loadFire = be.loadValid && be.loadReady;
	assign storeFire = be.storeValid && be.storeReady;

	oramStash stash0 (
		.Clock       (Clock),
		.arstN       (arstN),
		.insertSlot  (rdData),
		.insertValid (rdValid && rdReady),
		.lookAddr    (be.addr),
		.setLeaf     (be.newLeaf),
		.setLeafEn   (state == Serve),
		.writeData   (be.storeData),
		.writeEn     (storeFire),
		.evictLevel  (wrLevel),
		.evictLeaf   (be.oldLeaf),
		.evictTake   (DRAMWriteDataValid && DRAMWriteDataReady),
		.readData    (be.loadData),
		.found       (found),
		.evictSlot   (DRAMWriteData)
	);

	// --------------------
	// Access FSM
	// --------------------

	always_ff @(posedge Clock or negedge arstN) begin
		if (!arstN) begin
			state <= Idle;
			cmdCnt <= '0;
			absCnt <= '0;
		end else begin
			case (state)
				Idle: begin
					cmdCnt <= '0;
					absCnt <= '0;
					if (be.cmdValid) state <= ReadCmd;
				end
				ReadCmd: begin
					if (DRAMCommandReady) begin
						cmdCnt <= lastBurst ? 3'd0 : cmdCnt + 3'd1;
						if (lastBurst) state <= Absorb;
					end
				end
				Absorb: begin
					if (rdValid) begin
						absCnt <= absCnt + 3'd1;
						if (absCnt == 3'(oramPkg::PathBursts - 1)) state <= Serve;
					end
				end
				Serve: begin
					if (loadFire || storeFire) state <= WriteCmd;
				end
				WriteCmd: begin
					// Command goes before its data beat
					if (DRAMCommandReady) state <= WriteData;
				end
				WriteData: begin
					if (DRAMWriteDataReady) begin
						cmdCnt <= cmdCnt + 3'd1;
						state <= lastBurst ? Done : WriteCmd;
					end
				end
				default: state <= Idle;
			endcase
		end
	end

endmodule

//--- verilog/tinyOramCore.sv
`timescale 1ns/1ps
/* Tiny Path ORAM core
   Front end, back end and path buffer behind client and DRAM streams */
module tinyOramCore (
	input  logic              Clock,
	input  logic              arstN,

	// Client commands and data
	input  oramPkg::cmdT      Cmd,
	input  oramPkg::addrT     PAddr,
	input  logic              CmdValid,
	output logic              CmdReady,
	input  oramPkg::dataT     DataIn,
	input  logic              DataInValid,
	output logic              DataInReady,
	output oramPkg::dataT     DataOut,
	output logic              DataOutValid,
	input  logic              DataOutReady,

	// DRAM command, read and write streams
	output dramPkg::dramAddrT DRAMAddress,
	output dramPkg::dramCmdT  DRAMCommand,
	output logic              DRAMCommandValid,
	input  logic              DRAMCommandReady,
	input  dramPkg::burstT    DRAMReadData,
	input  logic              DRAMReadDataValid,
	output dramPkg::burstT    DRAMWriteData,
	output logic              DRAMWriteDataValid,
	input  logic              DRAMWriteDataReady
);

	// Buffered read returns toward the stash
	dramPkg::burstT pbOutData;
	logic pbOutValid;
	logic pbOutReady;

	oramBackendIf be0 ();

	oramFrontend front0 (
		.Clock        (Clock),
		.arstN        (arstN),
		.Cmd          (Cmd),
		.PAddr        (PAddr),
		.CmdValid     (CmdValid),
		.CmdReady     (CmdReady),
		.DataIn       (DataIn),
		.DataInValid  (DataInValid),
		.DataInReady  (DataInReady),
		.DataOut      (DataOut),
		.DataOutValid (DataOutValid),
		.DataOutReady (DataOutReady),
		.be           (be0.front)
	);

	pathOramBackend back0 (
		.Clock              (Clock),
		.arstN              (arstN),
		.rdData             (pbOutData),
		.rdValid            (pbOutValid),
		.rdReady            (pbOutReady),
		.DRAMAddress        (DRAMAddress),
		.DRAMCommand        (DRAMCommand),
		.DRAMCommandValid   (DRAMCommandValid),
		.DRAMCommandReady   (DRAMCommandReady),
		.DRAMWriteData      (DRAMWriteData),
		.DRAMWriteDataValid (DRAMWriteDataValid),
		.DRAMWriteDataReady (DRAMWriteDataReady),
		.be                 (be0.back)
	);

	// Read data has no ready, the buffer takes every burst
	pathBuffer pbuf0 (
		.Clock    (Clock),
		.arstN    (arstN),
		.inData   (DRAMReadData),
		.inValid  (DRAMReadDataValid),
		.outData  (pbOutData),
		.outValid (pbOutValid),
		.outReady (pbOutReady)
	);

endmodule

//--- sim/dramModel.sv
`timescale 1ns/1ps
/* Behavioral DRAM for the ORAM tree
   Answers slot reads in order and checks tree placement on every write */
module dramModel (
	input  logic              Clock,
	input  logic              arstN,
	input  dramPkg::dramAddrT DRAMAddress,
	input  dramPkg::dramCmdT  DRAMCommand,
	input  logic              DRAMCommandValid,
	input  logic              DRAMCommandReady,
	output dramPkg::burstT    DRAMReadData,
	output logic              DRAMReadDataValid,
	input  dramPkg::burstT    DRAMWriteData,
	input  logic              DRAMWriteDataValid,
	input  logic              DRAMWriteDataReady,
	input  logic              respGo,
	output logic              fault
);

	// 7 buckets of 2 slots
	dramPkg::burstT mem [14];
	dramPkg::dramAddrT rdQ [$];
	dramPkg::dramAddrT wrQ [$];
	int writeCount;

	initial begin
		for (int i = 0; i < 14; i++) begin
			mem[i] = '0;
		end
		writeCount = 0;
		fault = 1'b0;
		DRAMReadData = '0;
		DRAMReadDataValid = 1'b0;
	end

	// A valid slot must lie on the path of its own leaf
	task automatic checkPlacement(input dramPkg::dramAddrT a, input dramPkg::burstT s);
		int bucket;
		int level;
		int pos;
		logic [1:0] leaf;
		bucket = int'(a) / 2;
		level = (bucket == 0) ? 0 : ((bucket <= 2) ? 1 : 2);
		pos = bucket - ((1 << level) - 1);
		leaf = s[dramPkg::SlotLeafLsb +: 2];
		if (s[dramPkg::SlotValidBit] && (int'(leaf) >> (2 - level)) != pos) begin
			$display("DRAM write puts a block of leaf %0d into bucket %0d off its path",
				leaf, bucket);
			fault = 1'b1;
		end
	endtask

	// Every block address at most once over the whole tree
	task automatic checkUnique();
		for (int i = 0; i < 14; i++) begin
			for (int j = i + 1; j < 14; j++) begin
				if (mem[i][dramPkg::SlotValidBit] && mem[j][dramPkg::SlotValidBit] &&
					mem[i][dramPkg::SlotAddrLsb +: 3] == mem[j][dramPkg::SlotAddrLsb +: 3]) begin
					$display("Block %0d is stored in DRAM slots %0d and %0d at once",
						mem[i][dramPkg::SlotAddrLsb +: 3], i, j);
					fault = 1'b1;
				end
			end
		end
	endtask

	// --------------------
	// Command and write capture
	// --------------------

	always @(posedge Clock) begin
		if (arstN && DRAMCommandValid && DRAMCommandReady) begin
			if (DRAMCommand == dramPkg::DramRead) begin
				rdQ.push_back(DRAMAddress);
			end else begin
				wrQ.push_back(DRAMAddress);
			end
		end
		if (arstN && DRAMWriteDataValid && DRAMWriteDataReady) begin
			if (wrQ.size() == 0) begin
				$display("DRAM write data arrived without a write command");
				fault = 1'b1;
			end else begin
				dramPkg::dramAddrT wa;
				wa = wrQ.pop_front();
				mem[wa] = DRAMWriteData;
				checkPlacement(wa, DRAMWriteData);
				writeCount++;
				// Whole path written back
				if (writeCount % 6 == 0) checkUnique();
			end
		end
	end

	// Read returns with random gaps, in command order
	always @(negedge Clock) begin
		if (respGo && rdQ.size() != 0) begin
			DRAMReadData <= mem[rdQ.pop_front()];
			DRAMReadDataValid <= 1'b1;
		end else begin
			DRAMReadDataValid <= 1'b0;
		end
	end

endmodule

//--- sim/tinyOramTb.sv
`timescale 1ns/1ps
/* Testbench for the tiny Path ORAM core
   Random reads and writes against a word model, DRAM path order checks */
module tinyOramTb;

	localparam int NumAccesses = 400;
	localparam int CyclesPerAccess = 200;
	localparam logic [31:0] Seed = 32'hc411b148;

	logic Clock;
	logic arstN;
	oramPkg::cmdT Cmd;
	oramPkg::addrT PAddr;
	logic CmdValid;
	logic CmdReady;
	oramPkg::dataT DataIn;
	logic DataInValid;
	logic DataInReady;
	oramPkg::dataT DataOut;
	logic DataOutValid;
	logic DataOutReady;
	dramPkg::dramAddrT DRAMAddress;
	dramPkg::dramCmdT DRAMCommand;
	logic DRAMCommandValid;
	logic DRAMCommandReady;
	dramPkg::burstT DRAMReadData;
	logic DRAMReadDataValid;
	dramPkg::burstT DRAMWriteData;
	logic DRAMWriteDataValid;
	logic DRAMWriteDataReady;
	logic respGo;
	logic dramFault;

	integer stimSeed;
	integer readySeed;
	logic [31:0] model [8];
	int readsIssued;
	int outCount;
	// DRAM commands of the current access
	dramPkg::dramAddrT accAddr [12];
	dramPkg::dramCmdT accCmd [12];
	int cmdCount;

	tinyOramCore dut0 (.*);

	dramModel dram0 (
		.Clock              (Clock),
		.arstN              (arstN),
		.DRAMAddress        (DRAMAddress),
		.DRAMCommand        (DRAMCommand),
		.DRAMCommandValid   (DRAMCommandValid),
		.DRAMCommandReady   (DRAMCommandReady),
		.DRAMReadData       (DRAMReadData),
		.DRAMReadDataValid  (DRAMReadDataValid),
		.DRAMWriteData      (DRAMWriteData),
		.DRAMWriteDataValid (DRAMWriteDataValid),
		.DRAMWriteDataReady (DRAMWriteDataReady),
		.respGo             (respGo),
		.fault              (dramFault)
	);

	initial begin
		Clock = 1'b0;
		forever #5 Clock = ~Clock;
	end

	task automatic checkValue(input string name, input logic [63:0] exp, input logic [63:0] act);
		if (exp !== act) begin
			$display("Error %s expected %h actual %h", name, exp, act);
			$display("TEST FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	// --------------------
	// Monitors
	// --------------------

	always @(posedge Clock) begin
		if (arstN && DRAMCommandValid && DRAMCommandReady) begin
			if (cmdCount < 12) begin
				accAddr[cmdCount] = DRAMAddress;
				accCmd[cmdCount] = DRAMCommand;
			end
			cmdCount++;
		end
		if (arstN && DataOutValid && DataOutReady) outCount++;
		if (dramFault) begin
			$display("DRAM model found a broken tree invariant");
			$display("TEST FAILED");
			$fatal(1, "tree invariant");
		end
	end

	// Random back-pressure from DRAM
	always @(negedge Clock) begin
		DRAMCommandReady <= ($random(readySeed) & 3) != 0;
		DRAMWriteDataReady <= ($random(readySeed) & 3) != 0;
		respGo <= ($random(readySeed) & 1) != 0;
	end

	// Reads root to leaf, writes leaf to root, one path
	task automatic verifyPath();
		int bk [3];
		int level;
		int j;
		checkValue("DRAM commands per access", 12, cmdCount);
		for (int i = 0; i < 12; i++) begin
			checkValue("DRAM command kind", (i < 6) ? dramPkg::DramRead : dramPkg::DramWrite,
				accCmd[i]);
		end
		bk[2] = int'(accAddr[5]) / 2;
		checkValue("last read in leaf level", 1, bk[2] >= 3 && bk[2] <= 6);
		bk[1] = (bk[2] - 1) / 2;
		bk[0] = (bk[1] - 1) / 2;
		for (int i = 0; i < 6; i++) begin
			level = i / 2;
			checkValue("read slot address", bk[level] * 2 + i % 2, accAddr[i]);
		end
		for (int i = 6; i < 12; i++) begin
			j = i - 6;
			level = 2 - j / 2;
			checkValue("write slot address", bk[level] * 2 + j % 2, accAddr[i]);
		end
		cmdCount = 0;
	endtask

	task automatic doAccess();
		logic [31:0] r;
		logic isWrite;
		oramPkg::addrT a;
		logic [31:0] d;
		logic done;
		logic [31:0] got;
		r = $random(stimSeed);
		isWrite = r[0];
		a = r[3:1];
		d = $random(stimSeed);
		repeat (int'(r[5:4])) @(negedge Clock);
		while (!CmdReady) @(negedge Clock);
		Cmd = isWrite ? oramPkg::CmdWrite : oramPkg::CmdRead;
		PAddr = a;
		CmdValid = 1'b1;
		@(negedge Clock);
		CmdValid = 1'b0;
		done = 1'b0;
		got = '0;
		if (isWrite) begin
			// Store beat after a random delay, held until taken
			DataIn = d;
			while (!done) begin
				if (!DataInValid) begin
					DataInValid = ($random(stimSeed) & 1) != 0;
				end
				done = DataInValid && DataInReady;
				@(negedge Clock);
			end
			DataInValid = 1'b0;
			model[a] = d;
		end else begin
			readsIssued++;
			while (!done) begin
				DataOutReady = ($random(stimSeed) & 1) != 0;
				if (DataOutValid && DataOutReady) begin
					done = 1'b1;
					got = DataOut;
				end
				@(negedge Clock);
			end
			checkValue("read data", model[a], got);
		end
		// Keep draining so any extra load beat gets counted
		while (!CmdReady) begin
			DataOutReady = ($random(stimSeed) & 1) != 0;
			@(negedge Clock);
		end
		DataOutReady = 1'b0;
		verifyPath();
		checkValue("load beats out", readsIssued, outCount);
	endtask

	// --------------------
	// Main sequence
	// --------------------

	initial begin
		stimSeed = Seed;
		readySeed = Seed;
		arstN = 1'b0;
		Cmd = oramPkg::CmdRead;
		PAddr = '0;
		CmdValid = 1'b0;
		DataIn = '0;
		DataInValid = 1'b0;
		DataOutReady = 1'b0;
		DRAMCommandReady = 1'b0;
		DRAMWriteDataReady = 1'b0;
		respGo = 1'b0;
		readsIssued = 0;
		outCount = 0;
		cmdCount = 0;
		for (int i = 0; i < 8; i++) begin
			model[i] = '0;
		end
		repeat (5) @(negedge Clock);
		arstN = 1'b1;
		@(negedge Clock);
		for (int n = 0; n < NumAccesses; n++) begin
			doAccess();
		end
		$display("TEST OK");
		$finish;
	end

	// Watchdog sized from the access count
	initial begin
		repeat (NumAccesses * CyclesPerAccess) @(posedge Clock);
		$display("Watchdog expired before all accesses finished");
		$display("TEST FAILED");
		$fatal(1, "timeout");
	end

endmodule

//--- compile.f
verilog/oramPkg.sv
verilog/dramPkg.sv
verilog/oramBackendIf.sv
verilog/oramFrontend.sv
verilog/pathBuffer.sv
verilog/oramStash.sv
verilog/pathOramBackend.sv
verilog/tinyOramCore.sv
sim/dramModel.sv
sim/tinyOramTb.sv

//--- Makefile
# Verilator build and run for the tiny Path ORAM core

VERILATOR ?= verilator
TOP       ?= tinyOramTb
RTL_TOP   ?= tinyOramCore
FILELIST  ?= compile.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "TEST OK" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)
